// File: Makefile
SRCS := $(shell cat files.f)

obj_dir/Vgpio_tb: files.f $(SRCS)
	verilator --binary --timing --top-module gpio_tb -f files.f -o Vgpio_tb

.PHONY: run clean

run: obj_dir/Vgpio_tb
	@out="$$(./obj_dir/Vgpio_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf obj_dir

// File: files.f
logic/gpio_pkg.sv
logic/gpio_apb_slave.sv
logic/gpio_pin.sv
logic/gpio_top.sv
test/gpio_tb.sv

// File: logic/gpio_apb_slave.sv
`timescale 1ns/100ps

module gpio_apb_slave #(
   parameter int n_io = 32
) (
   input  gpio_pkg::apb_req_t              apb_req_i,
   input  gpio_pkg::pin_cfg_t [n_io-1:0]   cfg_i,
   input  logic [n_io-1:0]                 gpin_i,
   input  logic [n_io-1:0]                 intr_i,
   input  logic [n_io-1:0]                 gpout_i,
   output gpio_pkg::wr_strobe_t            wr_o,
   output logic [n_io-1:0]                 cfg_we_o,
   output logic [gpio_pkg::bus_width-1:0]  rdata_o
);

   import gpio_pkg::*;

   reg_sel_e   reg_sel;
   logic [5:0] cfg_idx;
   logic       cfg_hit;
   logic       wr_access;
   pin_cfg_t   cfg_rd;

   // ----------------------------------------------------------------------
   // address decode
   // ----------------------------------------------------------------------
   assign cfg_idx = apb_req_i.paddr[7:2];

   always_comb
   begin
      if (apb_req_i.paddr < addr_intr)
      begin
         reg_sel = reg_config;
      end
      else
      begin
         case (apb_req_i.paddr)
            addr_intr:  reg_sel = reg_intr;
            addr_gpin:  reg_sel = reg_gpin;
            addr_gpout: reg_sel = reg_gpout;
            default:    reg_sel = reg_none;
         endcase
      end
   end

   // only the access phase of a write commits
   assign wr_access = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;

   // ----------------------------------------------------------------------
   // write strobes
   // ----------------------------------------------------------------------
   assign wr_o.intr_clr = wr_access && (reg_sel == reg_intr);
   assign wr_o.gpout_we = wr_access && (reg_sel == reg_gpout);
   assign wr_o.wdata    = apb_req_i.pwdata;

   // one-hot config select that skips indices at or above n_io
   always_comb
   begin
      cfg_we_o = '0;
      cfg_rd   = '0;
      cfg_hit  = 1'b0;
      for (int i = 0; i < n_io; i++)
      begin
         if (cfg_idx == 6'(i))
         begin
            cfg_hit     = 1'b1;
            cfg_rd      = cfg_i[i];
            cfg_we_o[i] = wr_access && (reg_sel == reg_config);
         end
      end
   end

   // ----------------------------------------------------------------------
   // read mux
   // ----------------------------------------------------------------------
   always_comb
   begin
      case (reg_sel)
         reg_config:
         begin
            if (cfg_hit)
            begin
               rdata_o = bus_width'(cfg_rd);
            end
            else
            begin
               rdata_o = '0;
            end
         end
         reg_intr:  rdata_o = bus_width'(intr_i);
         reg_gpin:  rdata_o = bus_width'(gpin_i);
         reg_gpout: rdata_o = bus_width'(gpout_i);
         default:   rdata_o = '0;
      endcase
   end

endmodule

// File: logic/gpio_pin.sv
`timescale 1ns/100ps

module gpio_pin #(
   parameter logic gpout_rst = 1'b0
) (
   input  logic                 PCLK,
   input  logic                 aresetn,
   input  logic                 gpio_in_i,
   input  logic                 cfg_we_i,
   input  gpio_pkg::wr_strobe_t wr_i,
   input  logic                 wdata_bit_i,
   output gpio_pkg::pin_cfg_t   cfg_o,
   output logic                 gpin_o,
   output logic                 intr_o,
   output logic                 gpout_o,
   output logic                 gpio_out_o,
   output logic                 gpio_oe_o,
   output logic                 int_o
);

   import gpio_pkg::*;

   pin_cfg_t   cfg_q;
   logic       sync1_q;
   logic       sync2_q;
   logic       sample_q;
   // bit 0 rising, bit 1 falling, bit 2 either
   logic [2:0] edge_det;
   logic [2:0] edge_q;
   logic       flag_clr;
   logic       int_sel;
   logic       status_q;
   logic       gpout_q;

   // ----------------------------------------------------------------------
   // configuration byte
   // ----------------------------------------------------------------------
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         cfg_q <= '0;
      end
      else if (cfg_we_i)
      begin
         cfg_q <= pin_cfg_t'(wr_i.wdata[7:0]);
      end
   end

   // ----------------------------------------------------------------------
   // input synchronizer and sample stage
   // ----------------------------------------------------------------------
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         sync1_q  <= 1'b0;
         sync2_q  <= 1'b0;
         sample_q <= 1'b0;
      end
      else
      begin
         sync1_q  <= gpio_in_i;
         sync2_q  <= sync1_q;
         sample_q <= sync2_q;
      end
   end

   // compare the newest synced value against the sample stage
   assign edge_det[0] = sync2_q & ~sample_q;
   assign edge_det[1] = ~sync2_q & sample_q;
   assign edge_det[2] = sync2_q ^ sample_q;

   // software clears by writing a one to this pin's bit
   assign flag_clr = wr_i.intr_clr & wdata_bit_i;

   // sticky edge flags where a new edge wins over a clear
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         edge_q <= '0;
      end
      else if (!cfg_q.int_en)
      begin
         edge_q <= '0;
      end
      else
      begin
         edge_q <= (edge_q & ~{3{flag_clr}}) | edge_det;
      end
   end

   // ----------------------------------------------------------------------
   // interrupt select and status
   // ----------------------------------------------------------------------
   always_comb
   begin
      case (cfg_q.int_type)
         irq_level_high: int_sel = sample_q;
         irq_level_low:  int_sel = ~sample_q;
         irq_edge_pos:   int_sel = edge_q[0];
         irq_edge_neg:   int_sel = edge_q[1];
         irq_edge_both:  int_sel = edge_q[2];
         default:        int_sel = 1'b0;
      endcase
   end

   assign int_o = cfg_q.int_en & int_sel;

   // status lags int_o by one edge
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         status_q <= 1'b0;
      end
      else if (flag_clr)
      begin
         status_q <= 1'b0;
      end
      else
      begin
         status_q <= int_o;
      end
   end

   // ----------------------------------------------------------------------
   // output register
   // ----------------------------------------------------------------------
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         gpout_q <= gpout_rst;
      end
      else if (wr_i.gpout_we)
      begin
         gpout_q <= wdata_bit_i;
      end
   end

   assign gpio_out_o = cfg_q.out_en & gpout_q;
   // oe needs the output path enabled as well
   assign gpio_oe_o  = cfg_q.oe_en & cfg_q.out_en;
   assign gpin_o     = cfg_q.in_en & sample_q;

   assign cfg_o   = cfg_q;
   assign intr_o  = status_q;
   assign gpout_o = gpout_q;

endmodule

// File: logic/gpio_pkg.sv
package gpio_pkg;

   // ----------------------------------------------------------------------
   // bus
   // ----------------------------------------------------------------------
   localparam int bus_width = 32;

   typedef struct packed {
      logic                 psel;
      logic                 penable;
      logic                 pwrite;
      logic [7:0]           paddr;
      logic [bus_width-1:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [bus_width-1:0] prdata;
      logic                 pready;
      logic                 pslverr;
   } apb_rsp_t;

   // config bytes live below addr_intr
   localparam logic [7:0] addr_intr  = 8'h80;
   localparam logic [7:0] addr_gpin  = 8'h90;
   localparam logic [7:0] addr_gpout = 8'hA0;

   typedef enum logic [2:0] {
      reg_config,
      reg_intr,
      reg_gpin,
      reg_gpout,
      reg_none
   } reg_sel_e;

   // ----------------------------------------------------------------------
   // per-pin configuration
   // ----------------------------------------------------------------------
   // values 5..7 leave the pin without an interrupt
   typedef enum logic [2:0] {
      irq_level_high = 3'd0,
      irq_level_low  = 3'd1,
      irq_edge_pos   = 3'd2,
      irq_edge_neg   = 3'd3,
      irq_edge_both  = 3'd4
   } irq_type_e;

   typedef struct packed {
      irq_type_e int_type;
      logic      spare;
      logic      int_en;
      logic      oe_en;
      logic      in_en;
      logic      out_en;
   } pin_cfg_t;

   // write strobes fanned out to every pin
   typedef struct packed {
      logic                 intr_clr;
      logic                 gpout_we;
      logic [bus_width-1:0] wdata;
   } wr_strobe_t;

endpackage

// File: logic/gpio_top.sv
`timescale 1ns/100ps

module gpio_top #(
   parameter int          n_io        = 32,
   parameter logic [31:0] gpout_reset = 32'h0000_0000
) (
   input  logic               PCLK,
   input  logic               aresetn,
   input  gpio_pkg::apb_req_t apb_req_i,
   output gpio_pkg::apb_rsp_t apb_rsp_o,
   input  logic [n_io-1:0]    gpio_in_i,
   output logic [n_io-1:0]    gpio_out_o,
   output logic [n_io-1:0]    gpio_oe_o,
   output logic [n_io-1:0]    int_o,
   output logic               int_or_o
);

   import gpio_pkg::*;

   wr_strobe_t                 wr;
   logic [n_io-1:0]            cfg_we;
   pin_cfg_t [n_io-1:0]        cfg;
   logic [n_io-1:0]            gpin;
   logic [n_io-1:0]            intr;
   logic [n_io-1:0]            gpout;
   logic [bus_width-1:0]       rdata;

   // ----------------------------------------------------------------------
   // bus side
   // ----------------------------------------------------------------------
   gpio_apb_slave #(
      .n_io (n_io)
   ) u_apb_slave (
      .apb_req_i (apb_req_i),
      .cfg_i     (cfg),
      .gpin_i    (gpin),
      .intr_i    (intr),
      .gpout_i   (gpout),
      .wr_o      (wr),
      .cfg_we_o  (cfg_we),
      .rdata_o   (rdata)
   );

   // zero-wait slave that never errors
   assign apb_rsp_o.prdata  = rdata;
   assign apb_rsp_o.pready  = 1'b1;
   assign apb_rsp_o.pslverr = 1'b0;

   // ----------------------------------------------------------------------
   // pin slices
   // ----------------------------------------------------------------------
   for (genvar i = 0; i < n_io; i++)
   begin : g_pin
      gpio_pin #(
         .gpout_rst (gpout_reset[i])
      ) u_pin (
         .PCLK        (PCLK),
         .aresetn     (aresetn),
         .gpio_in_i   (gpio_in_i[i]),
         .cfg_we_i    (cfg_we[i]),
         .wr_i        (wr),
         .wdata_bit_i (wr.wdata[i]),
         .cfg_o       (cfg[i]),
         .gpin_o      (gpin[i]),
         .intr_o      (intr[i]),
         .gpout_o     (gpout[i]),
         .gpio_out_o  (gpio_out_o[i]),
         .gpio_oe_o   (gpio_oe_o[i]),
         .int_o       (int_o[i])
      );
   end

   assign int_or_o = |int_o;

endmodule

// File: test/gpio_tb.sv
`timescale 1ns/100ps

module gpio_tb;

   import gpio_pkg::*;

   localparam int          n_io        = 24;
   localparam logic [31:0] gpout_reset = 32'h00A5_0F3C;
   localparam int          max_wait    = 16;

   typedef enum logic [2:0] {
      op_write,
      op_read,
      op_drive,
      op_drive_rand,
      op_read_rand,
      op_pins
   } op_e;

   // for op_pins the address picks the output (0 out, 1 oe, 2 int, 3 int_or)
   typedef struct packed {
      logic [3:0]  tid;
      op_e         op;
      logic [7:0]  addr;
      logic [31:0] data;
      logic [31:0] exp;
   } row_t;

   logic            PCLK;
   logic            aresetn;
   apb_req_t        apb_req;
   apb_rsp_t        apb_rsp;
   logic [n_io-1:0] gpio_in;
   logic [n_io-1:0] gpio_out;
   logic [n_io-1:0] gpio_oe;
   logic [n_io-1:0] int_vec;
   logic            int_or;

   row_t        rows[$];
   string       test_names[6] = '{"reset state", "config registers", "output path",
                                  "input path", "interrupt types", "enable clears"};
   string       pin_names[4]  = '{"gpio_out_o", "gpio_oe_o", "int_o", "int_or_o"};
   logic [31:0] rand_in;
   int          test_errs;
   int          total_errs;
   int          tests_passed;
   int          tests_failed;
   bit          timed_out;

   gpio_top #(
      .n_io        (n_io),
      .gpout_reset (gpout_reset)
   ) gpio_top_i (
      .PCLK       (PCLK),
      .aresetn    (aresetn),
      .apb_req_i  (apb_req),
      .apb_rsp_o  (apb_rsp),
      .gpio_in_i  (gpio_in),
      .gpio_out_o (gpio_out),
      .gpio_oe_o  (gpio_oe),
      .int_o      (int_vec),
      .int_or_o   (int_or)
   );

   initial
   begin
      PCLK = 1'b0;
      forever
      begin
         #2 PCLK = ~PCLK;
      end
   end

   // ----------------------------------------------------------------------
   // helpers
   // ----------------------------------------------------------------------
   task automatic add_row(input int tid, input op_e op, input logic [7:0] addr,
                          input logic [31:0] data, input logic [31:0] exp);
      rows.push_back(row_t'{4'(tid), op, addr, data, exp});
   endtask

   task automatic compare(input string name, input logic [31:0] exp,
                          input logic [31:0] act);
      if (act !== exp)
      begin
         $display("mismatch at %0d ns: %s expected 0x%h got 0x%h", $time, name, exp, act);
         test_errs++;
      end
   endtask

   // setup cycle, then access cycle until pready
   task automatic apb_xfer(input logic wr, input logic [7:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
      int n;
      n = 0;
      apb_req = apb_req_t'{1'b1, 1'b0, wr, addr, wdata};
      @(posedge PCLK);
      #1;
      apb_req.penable = 1'b1;
      while (!apb_rsp.pready && n < max_wait)
      begin
         @(posedge PCLK);
         #1;
         n++;
      end
      if (!apb_rsp.pready)
      begin
         $display("error: access to address 0x%h never saw pready", addr);
         timed_out = 1'b1;
         test_errs++;
      end
      compare("pslverr", 32'h0, 32'(apb_rsp.pslverr));
      rdata = apb_rsp.prdata;
      @(posedge PCLK);
      #1;
      apb_req = '0;
   endtask

   // input reaches the sample stage after 3 edges
   task automatic drive_pins(input logic [n_io-1:0] val);
      gpio_in = val;
      for (int i = 0; i < 3; i++)
      begin
         @(posedge PCLK);
         #1;
      end
   endtask

   function automatic logic [31:0] pin_value(input logic [7:0] sel);
      case (sel)
         8'd0:    pin_value = 32'(gpio_out);
         8'd1:    pin_value = 32'(gpio_oe);
         8'd2:    pin_value = 32'(int_vec);
         default: pin_value = 32'(int_or);
      endcase
   endfunction

   task automatic report_test(input int tid);
      if (test_errs == 0)
      begin
         $display("test %0d (%s) passed", tid, test_names[tid]);
         tests_passed++;
      end
      else
      begin
         $display("test %0d (%s) failed, %0d errors", tid, test_names[tid], test_errs);
         tests_failed++;
      end
      total_errs += test_errs;
      test_errs = 0;
   endtask

   // ----------------------------------------------------------------------
   // stimulus and expected values
   // ----------------------------------------------------------------------
   task automatic build_table();
      add_row(0, op_read,  8'h00, 32'h0, 32'h0);
      add_row(0, op_read,  8'hA0, 32'h0, 32'h00A5_0F3C);
      add_row(0, op_pins,  8'd0,  32'h0, 32'h0);
      add_row(0, op_pins,  8'd1,  32'h0, 32'h0);
      add_row(0, op_pins,  8'd2,  32'h0, 32'h0);
      add_row(0, op_pins,  8'd3,  32'h0, 32'h0);
      add_row(1, op_write, 8'h04, 32'h5A, 32'h0);
      add_row(1, op_read,  8'h04, 32'h0, 32'h5A);
      // pin 24 does not exist
      add_row(1, op_write, 8'h60, 32'hFF, 32'h0);
      add_row(1, op_pins,  8'd1,  32'h0, 32'h0);
      add_row(1, op_read,  8'h60, 32'h0, 32'h0);
      add_row(1, op_read,  8'h00, 32'h0, 32'h0);
      add_row(1, op_read,  8'hB0, 32'h0, 32'h0);
      // pins 0..3 cover every mix of out_en and oe_en
      add_row(2, op_write, 8'h04, 32'h01, 32'h0);
      add_row(2, op_write, 8'h08, 32'h04, 32'h0);
      add_row(2, op_write, 8'h0C, 32'h05, 32'h0);
      add_row(2, op_pins,  8'd0,  32'h0, 32'h08);
      add_row(2, op_pins,  8'd1,  32'h0, 32'h08);
      add_row(2, op_write, 8'hA0, 32'hFFFF_FFFF, 32'h0);
      add_row(2, op_read,  8'hA0, 32'h0, 32'h00FF_FFFF);
      add_row(2, op_pins,  8'd0,  32'h0, 32'h0A);
      // in_en on pins 4 and 23
      add_row(3, op_write, 8'h10, 32'h02, 32'h0);
      add_row(3, op_write, 8'h5C, 32'h02, 32'h0);
      add_row(3, op_drive_rand, 8'h00, 32'h0, 32'h0);
      add_row(3, op_read_rand,  8'h90, 32'h0, 32'h0080_0010);
      add_row(3, op_drive_rand, 8'h00, 32'h0, 32'h0);
      add_row(3, op_read_rand,  8'h90, 32'h0, 32'h0080_0010);
      add_row(3, op_drive, 8'h00, 32'h0, 32'h0);
      // pin 8 rising, pin 9 falling, pin 10 both
      add_row(4, op_write, 8'h20, 32'h48, 32'h0);
      add_row(4, op_write, 8'h24, 32'h68, 32'h0);
      add_row(4, op_write, 8'h28, 32'h88, 32'h0);
      add_row(4, op_pins,  8'd2,  32'h0, 32'h0);
      add_row(4, op_drive, 8'h00, 32'h700, 32'h0);
      add_row(4, op_pins,  8'd2,  32'h0, 32'h500);
      add_row(4, op_write, 8'h80, 32'h100, 32'h0);
      add_row(4, op_pins,  8'd2,  32'h0, 32'h400);
      add_row(4, op_drive, 8'h00, 32'h0, 32'h0);
      add_row(4, op_pins,  8'd2,  32'h0, 32'h600);
      add_row(4, op_read,  8'h80, 32'h0, 32'h600);
      add_row(4, op_write, 8'h80, 32'hFFFF_FFFF, 32'h0);
      add_row(4, op_pins,  8'd2,  32'h0, 32'h0);
      add_row(4, op_pins,  8'd3,  32'h0, 32'h0);
      // pin 11 level high, pin 12 level low
      add_row(4, op_write, 8'h2C, 32'h08, 32'h0);
      add_row(4, op_write, 8'h30, 32'h28, 32'h0);
      add_row(4, op_pins,  8'd2,  32'h0, 32'h1000);
      add_row(4, op_pins,  8'd3,  32'h0, 32'h1);
      add_row(4, op_drive, 8'h00, 32'h1800, 32'h0);
      add_row(4, op_pins,  8'd2,  32'h0, 32'h800);
      add_row(4, op_write, 8'h80, 32'hFFFF_FFFF, 32'h0);
      add_row(4, op_pins,  8'd2,  32'h0, 32'h800);
      add_row(4, op_read,  8'h80, 32'h0, 32'h800);
      add_row(4, op_write, 8'h2C, 32'h00, 32'h0);
      add_row(4, op_write, 8'h30, 32'h00, 32'h0);
      add_row(4, op_pins,  8'd3,  32'h0, 32'h0);
      // pending edges on pins 8 and 10, then int_en toggled on pin 8
      add_row(5, op_drive, 8'h00, 32'h500, 32'h0);
      add_row(5, op_pins,  8'd2,  32'h0, 32'h500);
      add_row(5, op_write, 8'h20, 32'h40, 32'h0);
      add_row(5, op_pins,  8'd2,  32'h0, 32'h400);
      add_row(5, op_write, 8'h20, 32'h48, 32'h0);
      add_row(5, op_pins,  8'd2,  32'h0, 32'h400);
   endtask

   // ----------------------------------------------------------------------
   // main sequence
   // ----------------------------------------------------------------------
   initial
   begin
      row_t        r;
      logic [31:0] rd;
      void'($urandom(32'hfe64_344b));
      aresetn      = 1'b0;
      apb_req      = '0;
      gpio_in      = '0;
      rand_in      = '0;
      test_errs    = 0;
      total_errs   = 0;
      tests_passed = 0;
      tests_failed = 0;
      timed_out    = 1'b0;
      build_table();
      for (int i = 0; i < 3; i++)
      begin
         @(posedge PCLK);
      end
      #1;
      aresetn = 1'b1;
      for (int k = 0; k < rows.size(); k++)
      begin
         r = rows[k];
         case (r.op)
            op_write:
            begin
               apb_xfer(1'b1, r.addr, r.data, rd);
            end
            op_read:
            begin
               apb_xfer(1'b0, r.addr, 32'h0, rd);
               compare($sformatf("prdata[0x%h]", r.addr), r.exp, rd);
            end
            op_drive:
            begin
               drive_pins(r.data[n_io-1:0]);
            end
            op_drive_rand:
            begin
               rand_in = $urandom & 32'h00FF_FFFF;
               drive_pins(rand_in[n_io-1:0]);
            end
            op_read_rand:
            begin
               apb_xfer(1'b0, r.addr, 32'h0, rd);
               // only pins with in_en show their input
               compare($sformatf("prdata[0x%h]", r.addr), rand_in & r.exp, rd);
            end
            default:
            begin
               compare(pin_names[int'(r.addr[1:0])], r.exp, pin_value(r.addr));
            end
         endcase
         if (timed_out || k == rows.size() - 1 || rows[k + 1].tid != r.tid)
         begin
            report_test(int'(r.tid));
         end
         if (timed_out)
         begin
            break;
         end
      end
      $display("%0d tests passed, %0d failed, %0d errors", tests_passed, tests_failed,
               total_errs);
      if (tests_failed == 0 && !timed_out)
      begin
         $display("TEST OK");
      end
      else
      begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule
